/* disp_consts.svh */
`ifndef DISP_CONSTS_SVH
`define DISP_CONSTS_SVH

//////////////////////////////////////////////////
// Pixel FIFO sizing
//////////////////////////////////////////////////
`define PIX_FIFO_DEPTH 16
// One word may already be in flight when the flag rises
`define PIX_FIFO_AFULL (`PIX_FIFO_DEPTH - 2)

//////////////////////////////////////////////////
// Pattern generator defaults
//////////////////////////////////////////////////
`define BAR_WIDTH  8
`define DEF_WIDTH  8'd4
`define DEF_HEIGHT 8'd2
`define DEF_COLOR  24'h30_90_E0

// DSI data type codes
`define DT_FRAME_START 8'h01
`define DT_FRAME_END   8'h11
`define DT_RGB888      8'h3E

// Register port address width
`define REG_ADDR_W 3

`endif

/* disp_pkg.sv */
`default_nettype none

`include "disp_consts.svh"

package disp_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // FIFO entry
    // frame_last without line_last marks the frame descriptor word,
    // its pixel field holds the line word count in the low 16 bits
    typedef struct packed {
        pixel_t pix;
        logic   line_last;
        logic   frame_last;
    } pix_word_t;

    // One byte of the link stream
    typedef struct packed {
        logic [7:0] data;
        logic       sop;
        logic       eop;
    } link_byte_t;

    typedef enum logic [`REG_ADDR_W-1:0] {
        REG_CTRL    = 3'd0,
        REG_MODE    = 3'd1,
        REG_WIDTH   = 3'd2,
        REG_HEIGHT  = 3'd3,
        REG_COLOR_R = 3'd4,
        REG_COLOR_G = 3'd5,
        REG_COLOR_B = 3'd6
    } reg_addr_e;

    typedef enum logic [1:0] {
        PAT_SOLID    = 2'd0,
        PAT_BARS     = 2'd1,
        PAT_GRADIENT = 2'd2
    } pat_mode_e;

    typedef enum logic {
        GEN_IDLE,
        GEN_RUN
    } gen_state_e;

    typedef enum logic [2:0] {
        PKT_IDLE,
        PKT_FS,
        PKT_LHDR,
        PKT_PAY,
        PKT_SUM,
        PKT_FE
    } pkt_state_e;

endpackage

`default_nettype wire

/* pix_gen.sv */
`default_nettype none

`include "disp_consts.svh"

module pix_gen import disp_pkg::*; (
    input  logic       clk_sys_i,
    input  logic       rst_i,
    input  logic       reg_we_i,
    input  reg_addr_e  reg_addr_i,
    input  logic [7:0] reg_wdata_i,
    input  logic       afull_i,
    output logic       pix_wr_o,
    output pix_word_t  pix_o,
    output logic       busy_o,
    input  logic       frame_done_i
);

    // Register file
    pat_mode_e   mode_q;
    logic [7:0]  width_q;
    logic [7:0]  height_q;
    pixel_t      color_q;

    // Configuration of the frame in progress
    pat_mode_e   frm_mode_q;
    logic [7:0]  frm_width_q;
    logic [7:0]  frm_height_q;
    pixel_t      frm_color_q;

    gen_state_e  state_q;
    logic [7:0]  x_q;
    logic [7:0]  y_q;
    logic        all_sent_q;

    logic        start_req;
    logic        pix_emit;
    logic        line_last;
    logic        frame_last;
    logic [7:0]  bar_col;
    logic [15:0] word_cnt;
    pixel_t      pix_nxt;
    pix_word_t   desc_word;

    assign start_req  = reg_we_i && (reg_addr_i == REG_CTRL) && reg_wdata_i[0]
                        && (state_q == GEN_IDLE);
    assign pix_emit   = (state_q == GEN_RUN) && !all_sent_q && !afull_i;
    assign line_last  = (x_q == frm_width_q - 8'd1);
    assign frame_last = line_last && (y_q == frm_height_q - 8'd1);
    assign bar_col    = 8'(x_q / `BAR_WIDTH);
    assign busy_o     = (state_q == GEN_RUN);

    // Three payload bytes per pixel
    assign word_cnt  = {7'd0, width_q, 1'b0} + {8'd0, width_q};
    assign desc_word = '{pix: pixel_t'({8'd0, word_cnt}), line_last: 1'b0, frame_last: 1'b1};

    always_comb begin
        case (frm_mode_q)
            PAT_BARS: begin
                // Bits of the palette index map onto full-scale channels
                pix_nxt.r = {8{~bar_col[1]}};
                pix_nxt.g = {8{~bar_col[2]}};
                pix_nxt.b = {8{~bar_col[0]}};
            end
            PAT_GRADIENT: begin
                pix_nxt.r = x_q;
                pix_nxt.g = y_q;
                pix_nxt.b = frm_color_q.b;
            end
            default: pix_nxt = frm_color_q;
        endcase
    end

    //////////////////////////////////////////////////
    // Register port
    //////////////////////////////////////////////////
    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            mode_q   <= PAT_SOLID;
            width_q  <= `DEF_WIDTH;
            height_q <= `DEF_HEIGHT;
            color_q  <= `DEF_COLOR;
        end else if (reg_we_i) begin
            case (reg_addr_i)
                REG_MODE:    mode_q <= pat_mode_e'(reg_wdata_i[1:0]);
                REG_WIDTH: begin
                    if (reg_wdata_i != 8'd0) begin
                        width_q <= reg_wdata_i;
                    end
                end
                REG_HEIGHT: begin
                    if (reg_wdata_i != 8'd0) begin
                        height_q <= reg_wdata_i;
                    end
                end
                REG_COLOR_R: color_q.r <= reg_wdata_i;
                REG_COLOR_G: color_q.g <= reg_wdata_i;
                REG_COLOR_B: color_q.b <= reg_wdata_i;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Frame sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            state_q    <= GEN_IDLE;
            pix_wr_o   <= 1'b0;
            x_q        <= '0;
            y_q        <= '0;
            all_sent_q <= 1'b0;
        end else begin
            pix_wr_o <= 1'b0;
            case (state_q)
                GEN_IDLE: begin
                    // Descriptor goes out with the start, FIFO is drained by now
                    if (start_req) begin
                        state_q    <= GEN_RUN;
                        all_sent_q <= 1'b0;
                        pix_wr_o   <= 1'b1;
                    end
                end
                GEN_RUN: begin
                    if (frame_done_i) begin
                        state_q <= GEN_IDLE;
                    end else if (pix_emit) begin
                        pix_wr_o <= 1'b1;
                        x_q      <= line_last ? 8'd0 : x_q + 8'd1;
                        if (line_last) begin
                            y_q <= frame_last ? 8'd0 : y_q + 8'd1;
                        end
                        all_sent_q <= frame_last;
                    end
                end
                default: state_q <= GEN_IDLE;
            endcase
        end
    end

    // Frame configuration and output word
    always_ff @(posedge clk_sys_i) begin
        if (start_req) begin
            frm_mode_q   <= mode_q;
            frm_width_q  <= width_q;
            frm_height_q <= height_q;
            frm_color_q  <= color_q;
            pix_o        <= desc_word;
        end else if (pix_emit) begin
            pix_o <= '{pix: pix_nxt, line_last: line_last, frame_last: frame_last};
        end
    end

endmodule

`default_nettype wire

/* pix_fifo.sv */
`default_nettype none

`include "disp_consts.svh"

module pix_fifo import disp_pkg::*; (
    input  logic      clk_sys_i,
    input  logic      rst_i,
    input  logic      wr_i,
    input  pix_word_t wdata_i,
    input  logic      rd_i,
    output pix_word_t rdata_o,
    output logic      empty_o,
    output logic      afull_o
);

    localparam int AW = $clog2(`PIX_FIFO_DEPTH);
    localparam logic [AW:0] DEPTH_C = `PIX_FIFO_DEPTH;
    localparam logic [AW:0] AFULL_C = `PIX_FIFO_AFULL;

    pix_word_t     mem [`PIX_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic [AW:0]   count_nxt;
    logic          wr_en;
    logic          rd_en;

    assign empty_o = (count_q == '0);
    assign wr_en   = wr_i && (count_q != DEPTH_C);
    assign rd_en   = rd_i && !empty_o;

    // Head word straight from the array
    assign rdata_o = mem[rd_ptr_q];

    always_comb begin
        case ({wr_en, rd_en})
            2'b10:   count_nxt = count_q + 1'b1;
            2'b01:   count_nxt = count_q - 1'b1;
            default: count_nxt = count_q;
        endcase
    end

    always_ff @(posedge clk_sys_i) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            afull_o  <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_nxt;
            afull_o <= (count_nxt >= AFULL_C);
        end
    end

endmodule

`default_nettype wire

/* dsi_packer.sv */
`default_nettype none

`include "disp_consts.svh"

module dsi_packer import disp_pkg::*; (
    input  logic       clk_sys_i,
    input  logic       rst_i,
    input  logic       empty_i,
    input  pix_word_t  word_i,
    output logic       rd_o,
    input  logic       link_ready_i,
    output logic       byte_valid_o,
    output link_byte_t link_o,
    output logic       frame_done_o
);

    pkt_state_e  state_q;
    logic [1:0]  beat_q;
    logic [15:0] wc_q;
    logic [15:0] sum_q;
    pix_word_t   hold_q;
    logic        done_pend_q;

    logic        emit;
    link_byte_t  emit_byte;
    logic [7:0]  dt;
    logic [15:0] hdr_wc;
    logic [7:0]  hdr_byte;

    // Pop on frame entry (descriptor) and on the R beat of each pixel
    assign rd_o = link_ready_i && !empty_i
                  && ((state_q == PKT_IDLE) || ((state_q == PKT_PAY) && (beat_q == 2'd0)));

    //////////////////////////////////////////////////
    // Packet header bytes
    //////////////////////////////////////////////////
    always_comb begin
        case (state_q)
            PKT_FS:  dt = `DT_FRAME_START;
            PKT_FE:  dt = `DT_FRAME_END;
            default: dt = `DT_RGB888;
        endcase
        hdr_wc = (state_q == PKT_LHDR) ? wc_q : 16'd0;
        case (beat_q)
            2'd0:    hdr_byte = dt;
            2'd1:    hdr_byte = hdr_wc[7:0];
            2'd2:    hdr_byte = hdr_wc[15:8];
            default: hdr_byte = dt ^ hdr_wc[7:0] ^ hdr_wc[15:8];
        endcase
    end

    // Byte for this beat
    always_comb begin
        emit      = 1'b0;
        emit_byte = '0;
        case (state_q)
            PKT_FS, PKT_LHDR, PKT_FE: begin
                emit           = 1'b1;
                emit_byte.data = hdr_byte;
                emit_byte.sop  = (beat_q == 2'd0);
                // Long packet keeps going into its payload
                emit_byte.eop  = (beat_q == 2'd3) && (state_q != PKT_LHDR);
            end
            PKT_PAY: begin
                emit = (beat_q != 2'd0) || !empty_i;
                case (beat_q)
                    2'd0:    emit_byte.data = word_i.pix.r;
                    2'd1:    emit_byte.data = hold_q.pix.g;
                    default: emit_byte.data = hold_q.pix.b;
                endcase
            end
            PKT_SUM: begin
                emit           = 1'b1;
                emit_byte.data = beat_q[0] ? sum_q[15:8] : sum_q[7:0];
                emit_byte.eop  = beat_q[0];
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Packet FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            state_q      <= PKT_IDLE;
            beat_q       <= '0;
            byte_valid_o <= 1'b0;
            frame_done_o <= 1'b0;
            done_pend_q  <= 1'b0;
        end else begin
            frame_done_o <= done_pend_q;
            done_pend_q  <= 1'b0;
            byte_valid_o <= link_ready_i && emit;
            if (link_ready_i) begin
                case (state_q)
                    PKT_IDLE: begin
                        if (!empty_i) begin
                            state_q <= PKT_FS;
                            beat_q  <= '0;
                        end
                    end
                    PKT_FS, PKT_LHDR: begin
                        beat_q <= beat_q + 2'd1;
                        if (beat_q == 2'd3) begin
                            state_q <= (state_q == PKT_FS) ? PKT_LHDR : PKT_PAY;
                        end
                    end
                    PKT_PAY: begin
                        // Waits on an empty FIFO at the R beat
                        if (emit) begin
                            beat_q <= (beat_q == 2'd2) ? 2'd0 : beat_q + 2'd1;
                            if ((beat_q == 2'd2) && hold_q.line_last) begin
                                state_q <= PKT_SUM;
                            end
                        end
                    end
                    PKT_SUM: begin
                        beat_q <= beat_q + 2'd1;
                        if (beat_q[0]) begin
                            beat_q  <= '0;
                            state_q <= hold_q.frame_last ? PKT_FE : PKT_LHDR;
                        end
                    end
                    PKT_FE: begin
                        beat_q <= beat_q + 2'd1;
                        if (beat_q == 2'd3) begin
                            state_q     <= PKT_IDLE;
                            done_pend_q <= 1'b1;
                        end
                    end
                    default: state_q <= PKT_IDLE;
                endcase
            end
        end
    end

    // Output byte, current word and running sums
    always_ff @(posedge clk_sys_i) begin
        if (link_ready_i && emit) begin
            link_o <= emit_byte;
        end
        if (rd_o) begin
            hold_q <= word_i;
        end
        if (rd_o && (state_q == PKT_IDLE)) begin
            wc_q <= word_i.pix[15:0];
        end
        if (state_q == PKT_LHDR) begin
            sum_q <= '0;
        end else if (link_ready_i && emit && (state_q == PKT_PAY)) begin
            sum_q <= sum_q + {8'd0, emit_byte.data};
        end
    end

endmodule

`default_nettype wire

/* disp_top.sv */
`default_nettype none

module disp_top import disp_pkg::*; (
    input  logic       clk_sys_i,
    input  logic       rst_i,
    input  logic       reg_we_i,
    input  reg_addr_e  reg_addr_i,
    input  logic [7:0] reg_wdata_i,
    input  logic       link_ready_i,
    output logic       byte_valid_o,
    output link_byte_t link_o,
    output logic       frame_done_o,
    output logic       busy_o
);

    // Producer to FIFO
    logic      pix_wr;
    pix_word_t pix_word;
    logic      almost_full;

    // FIFO to packer
    logic      fifo_rd;
    pix_word_t fifo_word;
    logic      fifo_empty;

    pix_gen u_gen (
        .clk_sys_i    (clk_sys_i),
        .rst_i        (rst_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .afull_i      (almost_full),
        .pix_wr_o     (pix_wr),
        .pix_o        (pix_word),
        .busy_o       (busy_o),
        .frame_done_i (frame_done_o)
    );

    pix_fifo u_fifo (
        .clk_sys_i (clk_sys_i),
        .rst_i     (rst_i),
        .wr_i      (pix_wr),
        .wdata_i   (pix_word),
        .rd_i      (fifo_rd),
        .rdata_o   (fifo_word),
        .empty_o   (fifo_empty),
        .afull_o   (almost_full)
    );

    dsi_packer u_pack (
        .clk_sys_i    (clk_sys_i),
        .rst_i        (rst_i),
        .empty_i      (fifo_empty),
        .word_i       (fifo_word),
        .rd_o         (fifo_rd),
        .link_ready_i (link_ready_i),
        .byte_valid_o (byte_valid_o),
        .link_o       (link_o),
        .frame_done_o (frame_done_o)
    );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // Free running, half period per phase
    always begin
        #(PERIOD / 2);
        clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* disp_tb.sv */
`default_nettype none

`include "disp_consts.svh"

module disp_tb import disp_pkg::*; ();

    localparam int N_FRAMES    = 5;
    localparam int WDOG_MARGIN = 1000;
    localparam int IDLE_CYCLES = 200;
    // Geometry of each frame in run order, frame 0 runs on reset defaults
    localparam int FRAME_W [N_FRAMES] = '{4, 20, 5, 6, 70};
    localparam int FRAME_H [N_FRAMES] = '{2, 3, 4, 3, 1};

    typedef struct packed {
        pat_mode_e  mode;
        logic [7:0] width;
        logic [7:0] height;
        pixel_t     color;
    } frame_cfg_t;

    logic       clk_sys_i;
    logic       rst_i;
    logic       reg_we_i;
    reg_addr_e  reg_addr_i;
    logic [7:0] reg_wdata_i;
    logic       link_ready_i = 1'b1;
    logic       byte_valid_o;
    link_byte_t link_o;
    logic       frame_done_o;
    logic       busy_o;

    // Model state
    frame_cfg_t shadow;
    link_byte_t exp_q [$];
    int         frame_len_q [$];
    int         started_cnt = 0;
    int         done_cnt = 0;
    int         byte_cnt = 0;
    int         frame_got = 0;
    logic       busy_fall_pend = 1'b0;
    logic       rand_ready = 1'b0;
    integer     seed = 32'h6791_e065;
    integer     rnd;

    tb_clkgen #(.PERIOD(40)) u_clk (.clk_o(clk_sys_i));

    disp_top UUT (
        .clk_sys_i    (clk_sys_i),
        .rst_i        (rst_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .link_ready_i (link_ready_i),
        .byte_valid_o (byte_valid_o),
        .link_o       (link_o),
        .frame_done_o (frame_done_o),
        .busy_o       (busy_o)
    );

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input link_byte_t got, input link_byte_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf(
                "MISMATCH at %0t: byte %0d is %02h sop %b eop %b, expected %02h sop %b eop %b",
                $time, byte_cnt, got.data, got.sop, got.eop, exp.data, exp.sop, exp.eop));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_done(input int got_bytes);
        int exp_bytes;
        if (frame_len_q.size() == 0) begin
            stop_on_error("frame_done_o pulsed while no frame was running");
        end else begin
            exp_bytes = frame_len_q.pop_front();
            if (got_bytes != exp_bytes) begin
                stop_on_error($sformatf("MISMATCH at %0t: frame %0d ended after %0d bytes, expected %0d",
                                        $time, done_cnt, got_bytes, exp_bytes));
            end
            done_cnt++;
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic pixel_t bar_color(input int idx);
        case (idx % 8)
            0:       bar_color = 24'hFF_FF_FF;
            1:       bar_color = 24'hFF_FF_00;
            2:       bar_color = 24'h00_FF_FF;
            3:       bar_color = 24'h00_FF_00;
            4:       bar_color = 24'hFF_00_FF;
            5:       bar_color = 24'hFF_00_00;
            6:       bar_color = 24'h00_00_FF;
            default: bar_color = 24'h00_00_00;
        endcase
    endfunction

    function automatic pixel_t model_pixel(input frame_cfg_t cfg, input int x, input int y);
        pixel_t p;
        case (cfg.mode)
            PAT_BARS: p = bar_color(x / `BAR_WIDTH);
            PAT_GRADIENT: begin
                p.r = 8'(x);
                p.g = 8'(y);
                p.b = cfg.color.b;
            end
            default: p = cfg.color;
        endcase
        return p;
    endfunction

    function automatic void push_byte(input logic [7:0] data, input logic sop, input logic eop);
        link_byte_t b;
        b.data = data;
        b.sop  = sop;
        b.eop  = eop;
        exp_q.push_back(b);
    endfunction

    // Short packet with zero data, check byte is the XOR of the first three
    function automatic void push_short(input logic [7:0] dt);
        push_byte(dt, 1'b1, 1'b0);
        push_byte(8'h00, 1'b0, 1'b0);
        push_byte(8'h00, 1'b0, 1'b0);
        push_byte(dt ^ 8'h00 ^ 8'h00, 1'b0, 1'b1);
    endfunction

    function automatic int frame_bytes(input frame_cfg_t cfg);
        int          first;
        int          x;
        int          y;
        logic [15:0] wc;
        logic [15:0] sum;
        pixel_t      p;
        first = exp_q.size();
        push_short(`DT_FRAME_START);
        wc = 16'(3 * cfg.width);
        for (y = 0; y < cfg.height; y++) begin
            push_byte(`DT_RGB888, 1'b1, 1'b0);
            push_byte(wc[7:0], 1'b0, 1'b0);
            push_byte(wc[15:8], 1'b0, 1'b0);
            push_byte(`DT_RGB888 ^ wc[7:0] ^ wc[15:8], 1'b0, 1'b0);
            sum = 16'd0;
            for (x = 0; x < cfg.width; x++) begin
                p = model_pixel(cfg, x, y);
                push_byte(p.r, 1'b0, 1'b0);
                push_byte(p.g, 1'b0, 1'b0);
                push_byte(p.b, 1'b0, 1'b0);
                sum = sum + 16'(p.r) + 16'(p.g) + 16'(p.b);
            end
            push_byte(sum[7:0], 1'b0, 1'b0);
            push_byte(sum[15:8], 1'b0, 1'b1);
        end
        push_short(`DT_FRAME_END);
        return exp_q.size() - first;
    endfunction

    // Byte count of a frame: two short packets plus one long packet per line
    function automatic int frame_len(input int w, input int h);
        return 8 + h * (6 + 3 * w);
    endfunction

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    task automatic reg_write(input reg_addr_e addr, input logic [7:0] data);
        @(negedge clk_sys_i);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk_sys_i);
        reg_we_i = 1'b0;
        case (addr)
            REG_MODE:    shadow.mode = pat_mode_e'(data[1:0]);
            REG_WIDTH:   shadow.width = (data != 8'd0) ? data : shadow.width;
            REG_HEIGHT:  shadow.height = (data != 8'd0) ? data : shadow.height;
            REG_COLOR_R: shadow.color.r = data;
            REG_COLOR_G: shadow.color.g = data;
            REG_COLOR_B: shadow.color.b = data;
            default: ;
        endcase
    endtask

    task automatic set_geometry(input pat_mode_e mode, input int w, input int h);
        reg_write(REG_MODE, {6'd0, mode});
        reg_write(REG_WIDTH, 8'(w));
        reg_write(REG_HEIGHT, 8'(h));
    endtask

    task automatic start_frame();
        frame_len_q.push_back(frame_bytes(shadow));
        started_cnt++;
        reg_write(REG_CTRL, 8'h01);
        check_flag("busy_o after start", busy_o, 1'b1);
    endtask

    // Start written during a frame, the DUT must drop it
    task automatic extra_start();
        check_flag("busy_o before extra start", busy_o, 1'b1);
        reg_write(REG_CTRL, 8'h01);
    endtask

    task automatic wait_frames_done();
        while (done_cnt != started_cnt) begin
            @(negedge clk_sys_i);
        end
        repeat (4) @(negedge clk_sys_i);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    always @(negedge clk_sys_i) begin
        if (rand_ready) begin
            rnd          = $random(seed);
            link_ready_i = rnd[0];
        end else begin
            link_ready_i = 1'b1;
        end
    end

    initial begin
        rst_i       = 1'b1;
        reg_we_i    = 1'b0;
        reg_addr_i  = REG_CTRL;
        reg_wdata_i = 8'h00;
        shadow      = '{mode: PAT_SOLID, width: `DEF_WIDTH, height: `DEF_HEIGHT,
                        color: `DEF_COLOR};
        repeat (16) @(negedge clk_sys_i);
        rst_i = 1'b0;

        check_flag("busy_o after reset", busy_o, 1'b0);
        check_flag("byte_valid_o after reset", byte_valid_o, 1'b0);
        check_flag("frame_done_o after reset", frame_done_o, 1'b0);
        repeat (8) @(negedge clk_sys_i);

        // Solid fill on the reset defaults
        start_frame();
        wait_frames_done();

        set_geometry(PAT_BARS, FRAME_W[1], FRAME_H[1]);
        start_frame();
        wait_frames_done();

        set_geometry(PAT_GRADIENT, FRAME_W[2], FRAME_H[2]);
        reg_write(REG_COLOR_B, 8'h5A);
        start_frame();
        wait_frames_done();

        // Link stalls from here on
        rand_ready = 1'b1;
        set_geometry(PAT_SOLID, FRAME_W[3], FRAME_H[3]);
        reg_write(REG_COLOR_R, 8'h12);
        reg_write(REG_COLOR_G, 8'h34);
        reg_write(REG_COLOR_B, 8'h56);
        start_frame();

        // Next frame's setup, written while this one runs
        reg_write(REG_MODE, {6'd0, PAT_BARS});
        reg_write(REG_WIDTH, 8'(FRAME_W[4]));
        reg_write(REG_WIDTH, 8'd0);
        reg_write(REG_HEIGHT, 8'(FRAME_H[4]));
        reg_write(REG_HEIGHT, 8'd0);
        extra_start();
        wait_frames_done();

        start_frame();
        wait_frames_done();

        rand_ready = 1'b0;
        repeat (IDLE_CYCLES) @(negedge clk_sys_i);

        if ((exp_q.size() != 0) || (done_cnt != N_FRAMES)) begin
            stop_on_error($sformatf("Run ended with %0d bytes missing and %0d of %0d frames done",
                                    exp_q.size(), done_cnt, N_FRAMES));
        end else begin
            $display("Test OK");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Compare and watchdog
    //////////////////////////////////////////////////
    // Outputs are sampled mid cycle, away from the rising edge
    always @(negedge clk_sys_i) begin
        if (!rst_i) begin
            if (busy_fall_pend) begin
                check_flag("busy_o after frame_done_o", busy_o, 1'b0);
                busy_fall_pend = 1'b0;
            end
            if (byte_valid_o) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("A byte came out of the link while no byte was expected");
                end else begin
                    check_byte(link_o, exp_q.pop_front());
                    byte_cnt++;
                    frame_got++;
                end
            end
            if (frame_done_o) begin
                check_flag("busy_o at frame_done_o", busy_o, 1'b1);
                check_done(frame_got);
                frame_got      = 0;
                busy_fall_pend = 1'b1;
            end
        end
    end

    initial begin : watchdog
        int limit;
        int i;
        limit = 0;
        for (i = 0; i < N_FRAMES; i++) begin
            limit = limit + frame_len(FRAME_W[i], FRAME_H[i]);
        end
        limit = limit * 4 + WDOG_MARGIN;
        repeat (limit) @(posedge clk_sys_i);
        stop_on_error($sformatf("Timeout: the frames did not finish within %0d cycles", limit));
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
disp_pkg.sv
pix_gen.sv
pix_fifo.sv
dsi_packer.sv
disp_top.sv
tb_clkgen.sv
disp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module disp_tb -f filelist.f \
    -o disp_sim > build.log 2>&1 \
    && ./obj_dir/disp_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error, see build.log and sim.log"

grep -qx "Test OK" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
